// ==== logic/rs_cfg_pkg.sv ====
// reservation station geometry and execution latencies
`default_nettype none

package rs_cfg_pkg;

	// station geometry
	localparam int RS_ENT_NUM = 8;
	localparam int RS_IDX_W   = 3;

	// tag and index widths seen from the rest of the core
	localparam int PRF_IDX_W  = 6;
	localparam int ROB_IDX_W  = 5;
	localparam int BR_MASK_W  = 4;

	// execution latencies in cycles
	localparam int EX_CYCLES_MAX    = 4;
	localparam int EX_CYCLES_ALU    = 1;
	localparam int EX_CYCLES_BRANCH = 1;
	localparam int EX_CYCLES_STORE  = 1;
	localparam int EX_CYCLES_LOAD   = 3;
	localparam int EX_CYCLES_MULT   = 4;

endpackage

`default_nettype wire

// ==== logic/rs_types_pkg.sv ====
// typed vectors, unit codes and writeback schedule vectors of the station
`default_nettype none

package rs_types_pkg;

	import rs_cfg_pkg::*;

	typedef logic [PRF_IDX_W-1:0]     prf_tag_t;
	// ROB index with its wrap bit on top
	typedef logic [ROB_IDX_W:0]       rob_idx_t;
	typedef logic [BR_MASK_W-1:0]     br_mask_t;
	typedef logic [RS_IDX_W-1:0]      rs_idx_t;
	typedef logic [2:0]               fu_sel_t;
	typedef logic [EX_CYCLES_MAX-1:0] sched_vec_t;
	typedef logic [31:0]              ir_t;

	// function unit codes
	localparam fu_sel_t FU_NONE   = 3'd0;
	localparam fu_sel_t FU_ALU    = 3'd1;
	localparam fu_sel_t FU_BRANCH = 3'd2;
	localparam fu_sel_t FU_LOAD   = 3'd3;
	localparam fu_sel_t FU_STORE  = 3'd4;
	localparam fu_sel_t FU_MULT   = 3'd5;

	// one bit per unit, placed so that it leaves the vector at writeback
	localparam sched_vec_t SCHED_ALU    = sched_vec_t'(1) << (EX_CYCLES_MAX - EX_CYCLES_ALU);
	localparam sched_vec_t SCHED_BRANCH = sched_vec_t'(1) << (EX_CYCLES_MAX - EX_CYCLES_BRANCH);
	localparam sched_vec_t SCHED_STORE  = sched_vec_t'(1) << (EX_CYCLES_MAX - EX_CYCLES_STORE);
	localparam sched_vec_t SCHED_LOAD   = sched_vec_t'(1) << (EX_CYCLES_MAX - EX_CYCLES_LOAD);
	localparam sched_vec_t SCHED_MULT   = sched_vec_t'(1) << (EX_CYCLES_MAX - EX_CYCLES_MULT);

endpackage

`default_nettype wire

// ==== logic/rs_entry.sv ====
// single station slot holding one instruction with operand wakeup and branch mask
`default_nettype none
`timescale 1ns/1ps

module rs_entry import rs_types_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     load_i,
	input  logic     iss_en_i,
	input  prf_tag_t dest_tag_i,
	input  prf_tag_t opa_tag_i,
	input  prf_tag_t opb_tag_i,
	input  logic     opa_rdy_i,
	input  logic     opb_rdy_i,
	input  fu_sel_t  fu_sel_i,
	input  ir_t      ir_i,
	input  rob_idx_t rob_idx_i,
	input  br_mask_t br_mask_i,
	input  logic     cdb_vld_i,
	input  prf_tag_t cdb_tag_i,
	input  logic     br_recovery_i,
	input  logic     br_pred_correct_i,
	input  br_mask_t br_tag_fix_i,
	output logic     avail_o,
	output logic     rdy_o,
	output prf_tag_t dest_tag_o,
	output prf_tag_t opa_tag_o,
	output prf_tag_t opb_tag_o,
	output fu_sel_t  fu_sel_o,
	output ir_t      ir_o,
	output rob_idx_t rob_idx_o,
	output br_mask_t br_mask_o
);

	logic     vld_r;
	logic     opa_rdy_r;
	logic     opb_rdy_r;
	fu_sel_t  fu_sel_r;
	logic     opa_hit_new;
	logic     opb_hit_new;
	logic     opa_hit;
	logic     opb_hit;
	logic     squash;
	br_mask_t fix_clr;

	// bus matches against incoming and held tags
	assign opa_hit_new = cdb_vld_i & (cdb_tag_i == opa_tag_i);
	assign opb_hit_new = cdb_vld_i & (cdb_tag_i == opb_tag_i);
	assign opa_hit     = cdb_vld_i & (cdb_tag_i == opa_tag_o);
	assign opb_hit     = cdb_vld_i & (cdb_tag_i == opb_tag_o);

	assign squash  = br_recovery_i & (|(br_mask_o & br_tag_fix_i));
	assign fix_clr = br_pred_correct_i ? br_tag_fix_i : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_r     <= 1'b0;
			opa_rdy_r <= 1'b0;
			opb_rdy_r <= 1'b0;
		end else if (load_i) begin
			// a new op may take the slot being issued this cycle
			vld_r     <= 1'b1;
			opa_rdy_r <= opa_rdy_i | opa_hit_new;
			opb_rdy_r <= opb_rdy_i | opb_hit_new;
		end else if (iss_en_i || squash) begin
			vld_r <= 1'b0;
		end else begin
			opa_rdy_r <= opa_rdy_r | opa_hit;
			opb_rdy_r <= opb_rdy_r | opb_hit;
		end
	end

	always_ff @(posedge clk) begin
		if (load_i) begin
			dest_tag_o <= dest_tag_i;
			opa_tag_o  <= opa_tag_i;
			opb_tag_o  <= opb_tag_i;
			fu_sel_r   <= fu_sel_i;
			ir_o       <= ir_i;
			rob_idx_o  <= rob_idx_i;
			br_mask_o  <= br_mask_i & ~fix_clr;
		end else begin
			br_mask_o <= br_mask_o & ~fix_clr;
		end
	end

	assign avail_o  = ~vld_r;
	assign rdy_o    = vld_r & opa_rdy_r & opb_rdy_r;
	assign fu_sel_o = vld_r ? fu_sel_r : FU_NONE;

endmodule

`default_nettype wire

// ==== logic/oldest_select.sv ====
// oldest-first selector, grants the requester with the smallest corrected ROB index
`default_nettype none
`timescale 1ns/1ps

module oldest_select import rs_cfg_pkg::*, rs_types_pkg::*; (
	input  logic [RS_ENT_NUM-1:0]            req_i,
	input  rob_idx_t [RS_ENT_NUM-1:0]        age_i,
	output logic [RS_ENT_NUM-1:0]            gnt_o,
	output rs_idx_t                          idx_o,
	output logic                             vld_o
);

	always_comb begin
		logic     nd_vld [RS_ENT_NUM];
		rob_idx_t nd_age [RS_ENT_NUM];
		rs_idx_t  nd_idx [RS_ENT_NUM];

		for (int i = 0; i < RS_ENT_NUM; i++) begin
			nd_vld[i] = req_i[i];
			nd_age[i] = age_i[i];
			nd_idx[i] = rs_idx_t'(i);
		end

		// pairwise tree, each winner lands in the left node
		for (int s = 1; s < RS_ENT_NUM; s = s * 2) begin
			for (int i = 0; i + s < RS_ENT_NUM; i = i + 2 * s) begin
				// right side only wins when strictly older
				if (nd_vld[i+s] && (!nd_vld[i] || (nd_age[i+s] < nd_age[i]))) begin
					nd_vld[i] = 1'b1;
					nd_age[i] = nd_age[i+s];
					nd_idx[i] = nd_idx[i+s];
				end
			end
		end

		vld_o = nd_vld[0];
		idx_o = nd_idx[0];
		gnt_o = '0;
		if (nd_vld[0]) begin
			gnt_o[nd_idx[0]] = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/wb_scheduler.sv ====
// writeback slot reservation, blocks entries whose completion would collide
`default_nettype none
`timescale 1ns/1ps

module wb_scheduler import rs_cfg_pkg::*, rs_types_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      hold_i,
	input  fu_sel_t [RS_ENT_NUM-1:0]  fu_sel_i,
	output logic [RS_ENT_NUM-1:0]     allow_o,
	input  logic                      iss_vld_i,
	input  rs_idx_t                   iss_idx_i
);

	sched_vec_t                  sched_r;
	sched_vec_t                  sched_sh;
	sched_vec_t [RS_ENT_NUM-1:0] ent_vec;

	// reserved slots as seen one cycle later
	assign sched_sh = {sched_r[EX_CYCLES_MAX-2:0], 1'b0};

	always_comb begin
		for (int j = 0; j < RS_ENT_NUM; j++) begin
			case (fu_sel_i[j])
				FU_NONE:   ent_vec[j] = '0;
				FU_ALU:    ent_vec[j] = SCHED_ALU;
				FU_BRANCH: ent_vec[j] = SCHED_BRANCH;
				FU_LOAD:   ent_vec[j] = SCHED_LOAD;
				FU_STORE:  ent_vec[j] = SCHED_STORE;
				FU_MULT:   ent_vec[j] = SCHED_MULT;
				// unknown unit, block it
				default:   ent_vec[j] = '1;
			endcase
			allow_o[j] = ~|(ent_vec[j] & sched_sh);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sched_r <= '0;
		end else if (!hold_i) begin
			if (iss_vld_i) begin
				sched_r <= sched_sh | ent_vec[iss_idx_i];
			end else begin
				sched_r <= sched_sh;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/rs_ctrl.sv ====
// station control for dispatch, age correction, issue arbitration and output register
`default_nettype none
`timescale 1ns/1ps

module rs_ctrl import rs_cfg_pkg::*, rs_types_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       dp_vld_i,
	input  logic                       stall_dp_i,
	input  logic                       br_recovery_i,
	input  logic                       issue_stall_i,
	input  logic                       ld_iss_en_i,
	input  rob_idx_t                   rob_idx_i,
	input  logic [RS_ENT_NUM-1:0]      avail_i,
	input  logic [RS_ENT_NUM-1:0]      rdy_i,
	input  logic [RS_ENT_NUM-1:0]      allow_i,
	input  fu_sel_t [RS_ENT_NUM-1:0]   fu_sel_i,
	input  rob_idx_t [RS_ENT_NUM-1:0]  rob_idx_ent_i,
	input  prf_tag_t [RS_ENT_NUM-1:0]  dest_tag_ent_i,
	input  prf_tag_t [RS_ENT_NUM-1:0]  opa_tag_ent_i,
	input  prf_tag_t [RS_ENT_NUM-1:0]  opb_tag_ent_i,
	input  ir_t [RS_ENT_NUM-1:0]       ir_ent_i,
	input  br_mask_t [RS_ENT_NUM-1:0]  br_mask_ent_i,
	input  logic [RS_ENT_NUM-1:0]      gnt_ld_i,
	input  logic [RS_ENT_NUM-1:0]      gnt_nld_i,
	input  rs_idx_t                    idx_ld_i,
	input  rs_idx_t                    idx_nld_i,
	input  logic                       vld_ld_i,
	input  logic                       vld_nld_i,
	output logic [RS_ENT_NUM-1:0]      load_o,
	output logic [RS_ENT_NUM-1:0]      iss_en_o,
	output rob_idx_t [RS_ENT_NUM-1:0]  age_o,
	output logic [RS_ENT_NUM-1:0]      req_ld_o,
	output logic [RS_ENT_NUM-1:0]      req_nld_o,
	output logic                       iss_vld_int_o,
	output rs_idx_t                    iss_idx_int_o,
	output logic                       full_o,
	output logic                       iss_vld_o,
	output prf_tag_t                   iss_dest_tag_o,
	output prf_tag_t                   iss_opa_tag_o,
	output prf_tag_t                   iss_opb_tag_o,
	output fu_sel_t                    iss_fu_sel_o,
	output ir_t                        iss_ir_o,
	output rob_idx_t                   iss_rob_idx_o,
	output br_mask_t                   iss_br_mask_o
);

	logic                  dp_en;
	logic                  no_free;
	logic                  iss_go;
	logic                  ld_win;
	logic                  rob_msb_r;
	logic                  rob_ovf_r;
	logic [RS_ENT_NUM-1:0] load_free;
	logic [RS_ENT_NUM-1:0] is_ld;

	// ************************************************************
	// dispatch
	// ************************************************************
	assign dp_en   = dp_vld_i & ~stall_dp_i & ~br_recovery_i;
	assign no_free = ~|avail_i;

	// lowest numbered free slot
	always_comb begin
		load_free = '0;
		for (int k = RS_ENT_NUM - 1; k >= 0; k--) begin
			if (avail_i[k]) begin
				load_free    = '0;
				load_free[k] = 1'b1;
			end
		end
	end

	// when full, reuse the slot leaving this cycle
	assign load_o = !dp_en ? '0 : (no_free ? iss_en_o : load_free);
	assign full_o = no_free & ~iss_vld_int_o;

	// wrap bit of the ROB changes lap, older lap must stay smaller
	always_ff @(posedge clk) begin
		if (rst) begin
			rob_msb_r <= 1'b0;
			rob_ovf_r <= 1'b0;
		end else if (dp_en && (rob_idx_i[ROB_IDX_W] != rob_msb_r)) begin
			rob_msb_r <= rob_idx_i[ROB_IDX_W];
			rob_ovf_r <= ~rob_idx_i[ROB_IDX_W];
		end
	end

	// ************************************************************
	// issue
	// ************************************************************
	always_comb begin
		for (int k = 0; k < RS_ENT_NUM; k++) begin
			age_o[k] = rob_idx_ent_i[k];
			if (rob_ovf_r) begin
				age_o[k][ROB_IDX_W] = ~rob_idx_ent_i[k][ROB_IDX_W];
			end
			is_ld[k] = (fu_sel_i[k] == FU_LOAD);
		end
	end

	assign req_ld_o  = rdy_i & allow_i & is_ld;
	assign req_nld_o = rdy_i & allow_i & ~is_ld;

	assign iss_go        = ~issue_stall_i & ~br_recovery_i;
	assign ld_win        = vld_ld_i & ld_iss_en_i;
	assign iss_vld_int_o = iss_go & (ld_win | vld_nld_i);
	assign iss_idx_int_o = ld_win ? idx_ld_i : idx_nld_i;
	assign iss_en_o      = !iss_go ? '0 : (ld_win ? gnt_ld_i : gnt_nld_i);

	// output register, frozen under stall or recovery
	always_ff @(posedge clk) begin
		if (rst) begin
			iss_vld_o    <= 1'b0;
			iss_fu_sel_o <= FU_NONE;
		end else if (iss_go) begin
			iss_vld_o    <= iss_vld_int_o;
			iss_fu_sel_o <= iss_vld_int_o ? fu_sel_i[iss_idx_int_o] : FU_NONE;
		end
	end

	always_ff @(posedge clk) begin
		if (iss_go) begin
			iss_dest_tag_o <= dest_tag_ent_i[iss_idx_int_o];
			iss_opa_tag_o  <= opa_tag_ent_i[iss_idx_int_o];
			iss_opb_tag_o  <= opb_tag_ent_i[iss_idx_int_o];
			iss_ir_o       <= ir_ent_i[iss_idx_int_o];
			iss_rob_idx_o  <= rob_idx_ent_i[iss_idx_int_o];
			iss_br_mask_o  <= br_mask_ent_i[iss_idx_int_o];
		end
	end

endmodule

`default_nettype wire

// ==== logic/rs_top.sv ====
// reservation station top, entry array with selectors, writeback scheduler and control
`default_nettype none
`timescale 1ns/1ps

module rs_top import rs_cfg_pkg::*, rs_types_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	// dispatch
	input  logic     dp_vld_i,
	input  fu_sel_t  fu_sel_i,
	input  ir_t      ir_i,
	input  prf_tag_t dest_tag_i,
	input  prf_tag_t opa_tag_i,
	input  prf_tag_t opb_tag_i,
	input  logic     opa_rdy_i,
	input  logic     opb_rdy_i,
	input  rob_idx_t rob_idx_i,
	input  br_mask_t br_mask_i,
	// common data bus
	input  logic     cdb_vld_i,
	input  prf_tag_t cdb_tag_i,
	// branch resolution
	input  logic     br_recovery_i,
	input  logic     br_pred_correct_i,
	input  br_mask_t br_tag_fix_i,
	// stalls and load queue
	input  logic     stall_dp_i,
	input  logic     issue_stall_i,
	input  logic     ld_iss_en_i,
	// issue
	output logic     iss_vld_o,
	output prf_tag_t iss_dest_tag_o,
	output prf_tag_t iss_opa_tag_o,
	output prf_tag_t iss_opb_tag_o,
	output fu_sel_t  iss_fu_sel_o,
	output ir_t      iss_ir_o,
	output rob_idx_t iss_rob_idx_o,
	output br_mask_t iss_br_mask_o,
	output logic     full_o
);

	logic [RS_ENT_NUM-1:0]     avail_vec;
	logic [RS_ENT_NUM-1:0]     rdy_vec;
	logic [RS_ENT_NUM-1:0]     allow_vec;
	logic [RS_ENT_NUM-1:0]     load_vec;
	logic [RS_ENT_NUM-1:0]     iss_vec;
	logic [RS_ENT_NUM-1:0]     req_ld;
	logic [RS_ENT_NUM-1:0]     req_nld;
	logic [RS_ENT_NUM-1:0]     gnt_ld;
	logic [RS_ENT_NUM-1:0]     gnt_nld;
	fu_sel_t [RS_ENT_NUM-1:0]  fu_sel_vec;
	rob_idx_t [RS_ENT_NUM-1:0] rob_idx_vec;
	rob_idx_t [RS_ENT_NUM-1:0] age_vec;
	prf_tag_t [RS_ENT_NUM-1:0] dest_tag_vec;
	prf_tag_t [RS_ENT_NUM-1:0] opa_tag_vec;
	prf_tag_t [RS_ENT_NUM-1:0] opb_tag_vec;
	ir_t [RS_ENT_NUM-1:0]      ir_vec;
	br_mask_t [RS_ENT_NUM-1:0] br_mask_vec;
	rs_idx_t                   idx_ld;
	rs_idx_t                   idx_nld;
	logic                      vld_ld;
	logic                      vld_nld;
	logic                      iss_vld_int;
	rs_idx_t                   iss_idx_int;

	// ************************************************************
	// entry array
	// ************************************************************
	for (genvar i = 0; i < RS_ENT_NUM; i++) begin : g_ent
		rs_entry u_ent (
			.clk               (clk),
			.rst               (rst),
			.load_i            (load_vec[i]),
			.iss_en_i          (iss_vec[i]),
			.dest_tag_i        (dest_tag_i),
			.opa_tag_i         (opa_tag_i),
			.opb_tag_i         (opb_tag_i),
			.opa_rdy_i         (opa_rdy_i),
			.opb_rdy_i         (opb_rdy_i),
			.fu_sel_i          (fu_sel_i),
			.ir_i              (ir_i),
			.rob_idx_i         (rob_idx_i),
			.br_mask_i         (br_mask_i),
			.cdb_vld_i         (cdb_vld_i),
			.cdb_tag_i         (cdb_tag_i),
			.br_recovery_i     (br_recovery_i),
			.br_pred_correct_i (br_pred_correct_i),
			.br_tag_fix_i      (br_tag_fix_i),
			.avail_o           (avail_vec[i]),
			.rdy_o             (rdy_vec[i]),
			.dest_tag_o        (dest_tag_vec[i]),
			.opa_tag_o         (opa_tag_vec[i]),
			.opb_tag_o         (opb_tag_vec[i]),
			.fu_sel_o          (fu_sel_vec[i]),
			.ir_o              (ir_vec[i]),
			.rob_idx_o         (rob_idx_vec[i]),
			.br_mask_o         (br_mask_vec[i])
		);
	end

	// ************************************************************
	// selectors and writeback slots
	// ************************************************************
	oldest_select u_sel_ld (
		.req_i (req_ld),
		.age_i (age_vec),
		.gnt_o (gnt_ld),
		.idx_o (idx_ld),
		.vld_o (vld_ld)
	);

	oldest_select u_sel_nld (
		.req_i (req_nld),
		.age_i (age_vec),
		.gnt_o (gnt_nld),
		.idx_o (idx_nld),
		.vld_o (vld_nld)
	);

	wb_scheduler u_wb_sched (
		.clk       (clk),
		.rst       (rst),
		.hold_i    (issue_stall_i | br_recovery_i),
		.fu_sel_i  (fu_sel_vec),
		.allow_o   (allow_vec),
		.iss_vld_i (iss_vld_int),
		.iss_idx_i (iss_idx_int)
	);

	rs_ctrl u_ctrl (
		.clk            (clk),
		.rst            (rst),
		.dp_vld_i       (dp_vld_i),
		.stall_dp_i     (stall_dp_i),
		.br_recovery_i  (br_recovery_i),
		.issue_stall_i  (issue_stall_i),
		.ld_iss_en_i    (ld_iss_en_i),
		.rob_idx_i      (rob_idx_i),
		.avail_i        (avail_vec),
		.rdy_i          (rdy_vec),
		.allow_i        (allow_vec),
		.fu_sel_i       (fu_sel_vec),
		.rob_idx_ent_i  (rob_idx_vec),
		.dest_tag_ent_i (dest_tag_vec),
		.opa_tag_ent_i  (opa_tag_vec),
		.opb_tag_ent_i  (opb_tag_vec),
		.ir_ent_i       (ir_vec),
		.br_mask_ent_i  (br_mask_vec),
		.gnt_ld_i       (gnt_ld),
		.gnt_nld_i      (gnt_nld),
		.idx_ld_i       (idx_ld),
		.idx_nld_i      (idx_nld),
		.vld_ld_i       (vld_ld),
		.vld_nld_i      (vld_nld),
		.load_o         (load_vec),
		.iss_en_o       (iss_vec),
		.age_o          (age_vec),
		.req_ld_o       (req_ld),
		.req_nld_o      (req_nld),
		.iss_vld_int_o  (iss_vld_int),
		.iss_idx_int_o  (iss_idx_int),
		.full_o         (full_o),
		.iss_vld_o      (iss_vld_o),
		.iss_dest_tag_o (iss_dest_tag_o),
		.iss_opa_tag_o  (iss_opa_tag_o),
		.iss_opb_tag_o  (iss_opb_tag_o),
		.iss_fu_sel_o   (iss_fu_sel_o),
		.iss_ir_o       (iss_ir_o),
		.iss_rob_idx_o  (iss_rob_idx_o),
		.iss_br_mask_o  (iss_br_mask_o)
	);

endmodule

`default_nettype wire

// ==== verification/rs_assertions.sv ====
// concurrent checks on issue valid, issue stall and the full flag of the station
`default_nettype none
`timescale 1ns/1ps

module rs_assertions (
	input logic clk,
	input logic rst,
	input logic iss_vld_i,
	input logic issue_stall_i,
	input logic full_i,
	input logic dp_vld_i,
	input logic stall_dp_i,
	input logic br_recovery_i
);

	// output register is cleared by reset
	a_rst_idle: assert property (@(posedge clk) rst && $past(rst) |-> !iss_vld_i)
		else $error("issue valid high during reset");

	// a stalled cycle never starts a new issue
	a_stall_hold: assert property (@(posedge clk) disable iff (rst)
		issue_stall_i |=> !$rose(iss_vld_i))
		else $error("issue valid rose after a stalled cycle");

	// upstream must not dispatch into a full station
	a_full_no_dp: assert property (@(posedge clk) disable iff (rst)
		full_i |-> !(dp_vld_i && !stall_dp_i && !br_recovery_i))
		else $error("dispatch accepted while full");

endmodule

bind rs_top rs_assertions u_assertions (
	.clk           (clk),
	.rst           (rst),
	.iss_vld_i     (iss_vld_o),
	.issue_stall_i (issue_stall_i),
	.full_i        (full_o),
	.dp_vld_i      (dp_vld_i),
	.stall_dp_i    (stall_dp_i),
	.br_recovery_i (br_recovery_i)
);

`default_nettype wire

// ==== verification/rs_tb.sv ====
// reservation station testbench with LFSR stimulus and a cycle based reference model
`default_nettype none
`timescale 1ns/1ps

module rs_tb import rs_cfg_pkg::*, rs_types_pkg::*; ();

	localparam int RST_CYCLES = 16;
	localparam int NUM_TESTS  = 6;
	localparam int WD_CYCLES  = NUM_TESTS * 64 + RST_CYCLES;

	logic     clk;
	logic     rst;
	logic     dp_vld_i;
	fu_sel_t  fu_sel_i;
	ir_t      ir_i;
	prf_tag_t dest_tag_i;
	prf_tag_t opa_tag_i;
	prf_tag_t opb_tag_i;
	logic     opa_rdy_i;
	logic     opb_rdy_i;
	rob_idx_t rob_idx_i;
	br_mask_t br_mask_i;
	logic     cdb_vld_i;
	prf_tag_t cdb_tag_i;
	logic     br_recovery_i;
	logic     br_pred_correct_i;
	br_mask_t br_tag_fix_i;
	logic     stall_dp_i;
	logic     issue_stall_i;
	logic     ld_iss_en_i;
	logic     iss_vld_o;
	prf_tag_t iss_dest_tag_o;
	prf_tag_t iss_opa_tag_o;
	prf_tag_t iss_opb_tag_o;
	fu_sel_t  iss_fu_sel_o;
	ir_t      iss_ir_o;
	rob_idx_t iss_rob_idx_o;
	br_mask_t iss_br_mask_o;
	logic     full_o;

	// shadow copy of the station contents
	logic     sh_vld  [RS_ENT_NUM];
	logic     sh_ra   [RS_ENT_NUM];
	logic     sh_rb   [RS_ENT_NUM];
	prf_tag_t sh_ta   [RS_ENT_NUM];
	prf_tag_t sh_tb   [RS_ENT_NUM];
	prf_tag_t sh_dest [RS_ENT_NUM];
	fu_sel_t  sh_fu   [RS_ENT_NUM];
	ir_t      sh_ir   [RS_ENT_NUM];
	rob_idx_t sh_rob  [RS_ENT_NUM];
	br_mask_t sh_mask [RS_ENT_NUM];
	// writeback slots taken, counted in non-held cycles
	bit       busy    [0:4095];
	int       icyc;

	logic     exp_vld;
	prf_tag_t exp_dest;
	prf_tag_t exp_opa;
	prf_tag_t exp_opb;
	fu_sel_t  exp_fu;
	ir_t      exp_ir;
	rob_idx_t exp_rob;
	br_mask_t exp_mask;

	logic [31:0] lfsr_r;
	rob_idx_t    rob_cnt;
	prf_tag_t    last_dest;
	ir_t         last_ir;

	rs_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ************************************************************
	// helpers
	// ************************************************************
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		string msg;
		if (got !== exp) begin
			msg = $sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			fail_run(msg);
		end
	endtask

	// galois LFSR, one step per bit taken
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb     = lfsr_r[0];
			lfsr_r = lfsr_r >> 1;
			if (fb) begin
				lfsr_r = lfsr_r ^ 32'h8020_0003;
			end
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic int lat_of(input fu_sel_t fu);
		case (fu)
			FU_ALU:    return EX_CYCLES_ALU;
			FU_BRANCH: return EX_CYCLES_BRANCH;
			FU_STORE:  return EX_CYCLES_STORE;
			FU_LOAD:   return EX_CYCLES_LOAD;
			FU_MULT:   return EX_CYCLES_MULT;
			default:   return 0;
		endcase
	endfunction

	// reference pick: oldest legal load while allowed, else oldest legal non-load
	function automatic int choose_issue(input logic ld_en);
		int best_ld;
		int best_nld;
		best_ld  = -1;
		best_nld = -1;
		for (int i = 0; i < RS_ENT_NUM; i++) begin
			if (sh_vld[i] && sh_ra[i] && sh_rb[i] && !busy[icyc + lat_of(sh_fu[i])]) begin
				if (sh_fu[i] == FU_LOAD) begin
					if (best_ld < 0 || sh_rob[i] < sh_rob[best_ld]) begin
						best_ld = i;
					end
				end else if (best_nld < 0 || sh_rob[i] < sh_rob[best_nld]) begin
					best_nld = i;
				end
			end
		end
		if (ld_en && best_ld >= 0) begin
			return best_ld;
		end
		return best_nld;
	endfunction

	function automatic int shadow_count();
		int n;
		n = 0;
		for (int i = 0; i < RS_ENT_NUM; i++) begin
			if (sh_vld[i]) begin
				n++;
			end
		end
		return n;
	endfunction

	// ************************************************************
	// reference model, follows the station edge by edge
	// ************************************************************
	always @(posedge clk) begin
		int pick;
		int slot;
		if (rst) begin
			for (int i = 0; i < RS_ENT_NUM; i++) begin
				sh_vld[i] = 1'b0;
			end
			foreach (busy[k]) busy[k] = 1'b0;
			icyc    = 0;
			exp_vld = 1'b0;
		end else begin
			if (!issue_stall_i && !br_recovery_i) begin
				pick    = choose_issue(ld_iss_en_i);
				exp_vld = (pick >= 0);
				if (pick >= 0) begin
					exp_dest = sh_dest[pick];
					exp_opa  = sh_ta[pick];
					exp_opb  = sh_tb[pick];
					exp_fu   = sh_fu[pick];
					exp_ir   = sh_ir[pick];
					exp_rob  = sh_rob[pick];
					exp_mask = sh_mask[pick];
					busy[icyc + lat_of(sh_fu[pick])] = 1'b1;
					sh_vld[pick] = 1'b0;
				end
				icyc++;
			end
			for (int i = 0; i < RS_ENT_NUM; i++) begin
				if (br_recovery_i && |(sh_mask[i] & br_tag_fix_i)) begin
					sh_vld[i] = 1'b0;
				end
				if (cdb_vld_i && cdb_tag_i == sh_ta[i]) sh_ra[i] = 1'b1;
				if (cdb_vld_i && cdb_tag_i == sh_tb[i]) sh_rb[i] = 1'b1;
				if (br_pred_correct_i) sh_mask[i] = sh_mask[i] & ~br_tag_fix_i;
			end
			if (dp_vld_i && !stall_dp_i && !br_recovery_i) begin
				slot = -1;
				for (int i = RS_ENT_NUM - 1; i >= 0; i--) begin
					if (!sh_vld[i]) slot = i;
				end
				if (slot < 0) begin
					fail_run("dispatch accepted with every entry occupied");
				end
				sh_vld[slot]  = 1'b1;
				sh_ta[slot]   = opa_tag_i;
				sh_tb[slot]   = opb_tag_i;
				sh_ra[slot]   = opa_rdy_i | (cdb_vld_i && cdb_tag_i == opa_tag_i);
				sh_rb[slot]   = opb_rdy_i | (cdb_vld_i && cdb_tag_i == opb_tag_i);
				sh_dest[slot] = dest_tag_i;
				sh_fu[slot]   = fu_sel_i;
				sh_ir[slot]   = ir_i;
				sh_rob[slot]  = rob_idx_i;
				sh_mask[slot] = br_pred_correct_i ? (br_mask_i & ~br_tag_fix_i) : br_mask_i;
			end
		end
	end

	// compare on the falling edge where the outputs are settled
	always @(negedge clk) begin
		if (!rst) begin
			check_val("iss_vld_o", iss_vld_o, exp_vld);
			if (exp_vld) begin
				check_val("iss_rob_idx_o", iss_rob_idx_o, exp_rob);
				check_val("iss_dest_tag_o", iss_dest_tag_o, exp_dest);
				check_val("iss_opa_tag_o", iss_opa_tag_o, exp_opa);
				check_val("iss_opb_tag_o", iss_opb_tag_o, exp_opb);
				check_val("iss_fu_sel_o", iss_fu_sel_o, exp_fu);
				check_val("iss_ir_o", iss_ir_o, exp_ir);
				check_val("iss_br_mask_o", iss_br_mask_o, exp_mask);
			end
		end
	end

	initial begin
		repeat (WD_CYCLES) @(posedge clk);
		fail_run("watchdog expired before the tests finished");
	end

	// ************************************************************
	// stimulus
	// ************************************************************
	task automatic drive_quiet();
		dp_vld_i          <= 1'b0;
		cdb_vld_i         <= 1'b0;
		br_recovery_i     <= 1'b0;
		br_pred_correct_i <= 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			drive_quiet();
		end
	endtask

	task automatic dispatch(input fu_sel_t fu, input prf_tag_t ta, input logic ra,
		input prf_tag_t tb, input logic rb, input br_mask_t mask);
		@(posedge clk);
		drive_quiet();
		last_dest  = prf_tag_t'(lfsr_bits(PRF_IDX_W));
		last_ir    = lfsr_bits(32);
		dp_vld_i   <= 1'b1;
		fu_sel_i   <= fu;
		opa_tag_i  <= ta;
		opa_rdy_i  <= ra;
		opb_tag_i  <= tb;
		opb_rdy_i  <= rb;
		br_mask_i  <= mask;
		dest_tag_i <= last_dest;
		ir_i       <= last_ir;
		rob_idx_i  <= rob_cnt;
		rob_cnt    = rob_cnt + 1;
	endtask

	task automatic broadcast(input prf_tag_t tag);
		@(posedge clk);
		drive_quiet();
		cdb_vld_i <= 1'b1;
		cdb_tag_i <= tag;
	endtask

	task automatic resolve(input logic recover, input br_mask_t fix);
		@(posedge clk);
		drive_quiet();
		br_recovery_i     <= recover;
		br_pred_correct_i <= ~recover;
		br_tag_fix_i      <= fix;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		@(negedge clk);
		while (shadow_count() != 0 || exp_vld) begin
			idle(1);
			@(negedge clk);
			n++;
			if (n > 100) begin
				fail_run("station did not drain within 100 cycles");
			end
		end
	endtask

	initial begin
		fu_sel_t mix [4];
		mix = '{FU_ALU, FU_LOAD, FU_MULT, FU_BRANCH};
		lfsr_r = 32'hb5a7;
		rst = 1'b1;
		dp_vld_i = 1'b0;
		fu_sel_i = FU_NONE;
		ir_i = '0;
		dest_tag_i = '0;
		opa_tag_i = '0;
		opb_tag_i = '0;
		opa_rdy_i = 1'b0;
		opb_rdy_i = 1'b0;
		rob_idx_i = '0;
		br_mask_i = '0;
		cdb_vld_i = 1'b0;
		cdb_tag_i = '0;
		br_recovery_i = 1'b0;
		br_pred_correct_i = 1'b0;
		br_tag_fix_i = '0;
		stall_dp_i = 1'b0;
		issue_stall_i = 1'b0;
		ld_iss_en_i = 1'b1;
		rob_cnt = '0;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;

		// single ready op, two edges from dispatch to issue
		@(negedge clk);
		check_val("iss_vld_o", iss_vld_o, 0);
		check_val("iss_fu_sel_o", iss_fu_sel_o, FU_NONE);
		check_val("full_o", full_o, 0);
		dispatch(FU_ALU, 6'd1, 1'b1, 6'd2, 1'b1, 4'b0000);
		idle(1);
		@(posedge clk);
		@(negedge clk);
		check_val("iss_vld_o", iss_vld_o, 1);
		check_val("iss_dest_tag_o", iss_dest_tag_o, last_dest);
		check_val("iss_ir_o", iss_ir_o, last_ir);
		check_val("iss_rob_idx_o", iss_rob_idx_o, 0);
		wait_drain();

		// wakeup by bus, issue in ROB order
		rob_cnt = 6'd2;
		dispatch(FU_ALU, 6'd40, 1'b0, 6'd3, 1'b1, 4'b0000);
		rob_cnt = 6'd0;
		dispatch(FU_ALU, 6'd40, 1'b0, 6'd4, 1'b1, 4'b0000);
		dispatch(FU_ALU, 6'd5, 1'b1, 6'd40, 1'b0, 4'b0000);
		rob_cnt = 6'd3;
		dispatch(FU_MULT, 6'd41, 1'b0, 6'd6, 1'b1, 4'b0000);
		idle(3);
		broadcast(6'd40);
		broadcast(6'd41);
		wait_drain();

		// loads wait for the load queue
		@(posedge clk);
		ld_iss_en_i <= 1'b0;
		rob_cnt = '0;
		dispatch(FU_LOAD, 6'd7, 1'b1, 6'd8, 1'b1, 4'b0000);
		dispatch(FU_ALU, 6'd7, 1'b1, 6'd8, 1'b1, 4'b0000);
		dispatch(FU_LOAD, 6'd7, 1'b1, 6'd8, 1'b1, 4'b0000);
		dispatch(FU_ALU, 6'd7, 1'b1, 6'd8, 1'b1, 4'b0000);
		idle(8);
		@(negedge clk);
		check_val("iss_vld_o", iss_vld_o, 0);
		@(posedge clk);
		ld_iss_en_i <= 1'b1;
		wait_drain();

		// random unit mix, writeback slots must not collide
		rob_cnt = '0;
		for (int k = 0; k < 8; k++) begin
			dispatch(mix[lfsr_bits(2)], 6'd9, 1'b1, 6'd10, 1'b1, 4'b0000);
		end
		wait_drain();

		// squash on one branch bit, clear on another
		rob_cnt = '0;
		dispatch(FU_ALU, 6'd50, 1'b0, 6'd11, 1'b1, 4'b0010);
		dispatch(FU_ALU, 6'd50, 1'b0, 6'd11, 1'b1, 4'b0100);
		dispatch(FU_ALU, 6'd50, 1'b0, 6'd11, 1'b1, 4'b0010);
		dispatch(FU_ALU, 6'd50, 1'b0, 6'd11, 1'b1, 4'b0100);
		idle(1);
		resolve(1'b1, 4'b0010);
		resolve(1'b0, 4'b0100);
		broadcast(6'd50);
		wait_drain();

		// fill the station, then stall in the middle of draining
		rob_cnt = '0;
		for (int k = 0; k < RS_ENT_NUM; k++) begin
			dispatch(FU_ALU, 6'd55, 1'b0, 6'd12, 1'b1, 4'b0000);
		end
		idle(1);
		@(negedge clk);
		check_val("full_o", full_o, 1);
		broadcast(6'd55);
		idle(3);
		@(posedge clk);
		issue_stall_i <= 1'b1;
		idle(5);
		@(posedge clk);
		issue_stall_i <= 1'b0;
		wait_drain();

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/rs_cfg_pkg.sv
logic/rs_types_pkg.sv
logic/rs_entry.sv
logic/oldest_select.sv
logic/wb_scheduler.sv
logic/rs_ctrl.sv
logic/rs_top.sv
verification/rs_assertions.sv
verification/rs_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rs_tb \
	-f flist.f -Mdir obj_dir > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/Vrs_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" sim.log; then
	exit 0
else
	echo "pass line not found in sim.log"
	exit 1
fi
